/* Makefile */
TOP = execCoreTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f mipsExec.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

/* bench/clockGen.sv */
module clockGen (
    output logic clk,
    output logic rstN
);
    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 16;

    initial
    begin
        clk  = 1'b0;
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 rstN = 1'b1;
    end

    always #HALF_PERIOD clk = ~clk;

endmodule

/* bench/execCoreTb.sv */
module execCoreTb;
    import isaPkg::*;
    import datapathPkg::*;

    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_MARGIN = 20;
    localparam int DRIVE_DELAY    = 10;

    logic    clk;
    logic    rstN;
    logic    instrValid;
    wordT    instr;
    logic    wbValid;
    regAddrT wbAddr;
    wordT    wbData;
    logic    badInstr;

    // Stimulus rows and their expected writeback
    wordT    rowInstr [$];
    logic    expValid [$];
    regAddrT expAddr [$];
    wordT    expData [$];
    logic    expBad [$];

    // Architectural state of the model
    wordT modelReg [REG_COUNT];
    hiLoT modelHiLo;

    int curRow       = 0;
    int stage1       = -1;
    int stage2       = -1;
    int checkedCount = 0;
    int cycleCount   = 0;
    int cycleLimit   = 0;

    clockGen uClockGen (
        .clk(clk),
        .rstN(rstN)
    );

    execCore uut (
        .clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
        .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData), .badInstr(badInstr)
    );

    task automatic pushRow(wordT word, logic wr, regAddrT addr, wordT data, logic bad);
        rowInstr.push_back(word);
        expValid.push_back(wr && addr != '0);
        expAddr.push_back(addr);
        expData.push_back(data);
        expBad.push_back(bad);
        if (wr && addr != '0)
            modelReg[addr] = data;
    endtask

    task automatic regOp(funcT fn, regAddrT d, regAddrT s, regAddrT t, shamtT sa);
        wordT a;
        wordT b;
        wordT r;
        logic wr;
        a  = modelReg[s];
        b  = modelReg[t];
        r  = '0;
        wr = 1'b1;
        case (fn)
            FN_ADD, FN_ADDU: r = a + b;
            FN_SUB, FN_SUBU: r = a - b;
            FN_SLL:   r = b << sa;
            FN_SLLV:  r = b << a[4:0];
            FN_SRL:   r = b >> sa;
            FN_SRLV:  r = b >> a[4:0];
            FN_SRA:   r = $signed(b) >>> sa;
            FN_SRAV:  r = $signed(b) >>> a[4:0];
            FN_AND:   r = a & b;
            FN_OR:    r = a | b;
            FN_XOR:   r = a ^ b;
            FN_NOR:   r = ~(a | b);
            FN_SLT:   r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FN_SLTU:  r = (a < b) ? 32'd1 : 32'd0;
            FN_MOVN:
            begin
                r  = a;
                wr = (b != '0);
            end
            FN_MOVZ:
            begin
                r  = a;
                wr = (b == '0);
            end
            FN_MULT:  modelHiLo = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
            FN_MULTU: modelHiLo = {32'd0, a} * {32'd0, b};
            FN_MTHI:  modelHiLo[63:32] = a;
            FN_MTLO:  modelHiLo[31:0] = a;
            FN_MFHI:  r = modelHiLo[63:32];
            FN_MFLO:  r = modelHiLo[31:0];
            default:  r = '0;
        endcase
        if (fn inside {FN_MULT, FN_MULTU, FN_MTHI, FN_MTLO})
            wr = 1'b0;
        pushRow({OP_SPECIAL, s, t, d, sa, fn}, wr, d, r, 1'b0);
    endtask

    task automatic special2Op(funcT fn, regAddrT d, regAddrT s, regAddrT t);
        hiLoT ps;
        hiLoT pu;
        ps = $signed({{32{modelReg[s][31]}}, modelReg[s]})
           * $signed({{32{modelReg[t][31]}}, modelReg[t]});
        pu = {32'd0, modelReg[s]} * {32'd0, modelReg[t]};
        case (fn)
            FN_MADD:  modelHiLo = modelHiLo + ps;
            FN_MADDU: modelHiLo = modelHiLo + pu;
            FN_MSUB:  modelHiLo = modelHiLo - ps;
            FN_MSUBU: modelHiLo = modelHiLo - pu;
            default:  ;
        endcase
        pushRow({OP_SPECIAL2, s, t, d, 5'd0, fn}, fn == FN_MUL, d, ps[31:0], 1'b0);
    endtask

    task automatic immOp(opcodeT op, regAddrT t, regAddrT s, immT im);
        wordT a;
        wordT se;
        wordT ze;
        wordT r;
        a  = modelReg[s];
        se = {{16{im[15]}}, im};
        ze = {16'd0, im};
        case (op)
            OP_SLTI:  r = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
            OP_SLTIU: r = (a < se) ? 32'd1 : 32'd0;
            OP_ANDI:  r = a & ze;
            OP_ORI:   r = a | ze;
            OP_XORI:  r = a ^ ze;
            OP_LUI:   r = {im, 16'd0};
            default:  r = a + se;
        endcase
        pushRow({op, s, t, im}, 1'b1, t, r, 1'b0);
    endtask

    task automatic loadWord(regAddrT t, wordT v);
        immOp(OP_LUI, t, 5'd0, v[31:16]);
        immOp(OP_ORI, t, t, v[15:0]);
    endtask

    task automatic buildTable();
        funcT aluFns [13];
        wordT v;
        aluFns = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                   FN_SLT, FN_SLTU, FN_SLLV, FN_SRLV, FN_SRAV};
        for (int i = 0; i < REG_COUNT; i++)
            modelReg[i] = '0;
        modelHiLo = '0;

        // Sign and zero extension, each row reading the one before
        immOp(OP_ADDIU, 5'd1, 5'd0, 16'h7FFF);
        immOp(OP_ADDI, 5'd2, 5'd0, 16'h8000);
        immOp(OP_ADDIU, 5'd3, 5'd1, 16'hFFFF);
        immOp(OP_LUI, 5'd4, 5'd0, 16'h8001);
        immOp(OP_ORI, 5'd4, 5'd4, 16'hF00F);
        immOp(OP_ANDI, 5'd5, 5'd2, 16'h8001);
        immOp(OP_XORI, 5'd6, 5'd2, 16'hFFFF);
        immOp(OP_SLTI, 5'd7, 5'd2, 16'h0001);
        immOp(OP_SLTI, 5'd7, 5'd1, 16'hFFFF);
        immOp(OP_SLTIU, 5'd8, 5'd1, 16'hFFFF);
        immOp(OP_SLTIU, 5'd8, 5'd2, 16'h0005);
        immOp(OP_ADDIU, 5'd0, 5'd1, 16'h0005);

        loadWord(5'd9, $urandom());
        loadWord(5'd10, $urandom() | 32'h0000_0100);
        loadWord(5'd14, 32'h8000_0001);
        for (int i = 0; i < 13; i++)
        begin
            regOp(aluFns[i], 5'd12, 5'd9, 5'd10, 5'd0);
            regOp(aluFns[i], 5'd12, 5'd14, 5'd9, 5'd0);
        end
        v = $urandom();
        regOp(FN_SLL, 5'd13, 5'd0, 5'd9, v[4:0]);
        regOp(FN_SRL, 5'd13, 5'd0, 5'd14, v[9:5]);
        regOp(FN_SRA, 5'd13, 5'd0, 5'd14, v[14:10]);
        regOp(FN_ADD, 5'd0, 5'd9, 5'd10, 5'd0);
        regOp(FN_OR, 5'd16, 5'd0, 5'd0, 5'd0);

        // Conditional moves, taken and not taken
        regOp(FN_MOVN, 5'd17, 5'd9, 5'd10, 5'd0);
        regOp(FN_MOVN, 5'd17, 5'd10, 5'd0, 5'd0);
        regOp(FN_MOVZ, 5'd18, 5'd9, 5'd0, 5'd0);
        regOp(FN_MOVZ, 5'd18, 5'd10, 5'd14, 5'd0);

        regOp(FN_MULT, 5'd0, 5'd9, 5'd10, 5'd0);
        regOp(FN_MFHI, 5'd19, 5'd0, 5'd0, 5'd0);
        regOp(FN_MFLO, 5'd20, 5'd0, 5'd0, 5'd0);
        regOp(FN_MULTU, 5'd0, 5'd14, 5'd10, 5'd0);
        regOp(FN_MFHI, 5'd19, 5'd0, 5'd0, 5'd0);
        special2Op(FN_MADD, 5'd0, 5'd9, 5'd14);
        regOp(FN_MFHI, 5'd19, 5'd0, 5'd0, 5'd0);
        special2Op(FN_MADDU, 5'd0, 5'd9, 5'd14);
        regOp(FN_MFLO, 5'd20, 5'd0, 5'd0, 5'd0);
        special2Op(FN_MSUB, 5'd0, 5'd10, 5'd14);
        regOp(FN_MFHI, 5'd19, 5'd0, 5'd0, 5'd0);
        special2Op(FN_MSUBU, 5'd0, 5'd10, 5'd9);
        regOp(FN_MFHI, 5'd19, 5'd0, 5'd0, 5'd0);
        regOp(FN_MFLO, 5'd20, 5'd0, 5'd0, 5'd0);
        regOp(FN_MTHI, 5'd0, 5'd9, 5'd0, 5'd0);
        regOp(FN_MTLO, 5'd0, 5'd14, 5'd0, 5'd0);
        special2Op(FN_MUL, 5'd21, 5'd9, 5'd10);
        regOp(FN_MFHI, 5'd19, 5'd0, 5'd0, 5'd0);
        regOp(FN_MFLO, 5'd20, 5'd0, 5'd0, 5'd0);

        // Load, branch and unused function codes aimed at r9
        pushRow({6'h23, 5'd0, 5'd9, 16'h0004}, 1'b0, 5'd0, '0, 1'b1);
        pushRow({6'h04, 5'd9, 5'd9, 16'hFFFE}, 1'b0, 5'd0, '0, 1'b1);
        pushRow({OP_SPECIAL, 5'd10, 5'd10, 5'd9, 5'd0, 6'h38}, 1'b0, 5'd0, '0, 1'b1);
        pushRow({OP_SPECIAL2, 5'd10, 5'd0, 5'd9, 5'd0, 6'h20}, 1'b0, 5'd0, '0, 1'b1);
        regOp(FN_OR, 5'd22, 5'd9, 5'd0, 5'd0);

        // Dependent chain at full rate
        for (int i = 0; i < 6; i++)
        begin
            v = $urandom();
            immOp(OP_ADDIU, 5'd23, 5'd23, v[15:0]);
            regOp(FN_XOR, 5'd24, 5'd23, 5'd9, 5'd0);
            regOp(FN_ADDU, 5'd23, 5'd24, 5'd23, 5'd0);
        end
    endtask

    task automatic checkWord(wordT got, wordT exp, string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Result: FAILED");
            $fatal(1, "Stopped at the first error");
        end
    endtask

    task automatic checkAddr(regAddrT got, regAddrT exp, string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Result: FAILED");
            $fatal(1, "Stopped at the first error");
        end
    endtask

    task automatic checkFlag(logic got, logic exp, string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("Result: FAILED");
            $fatal(1, "Stopped at the first error");
        end
    endtask

    task automatic checkRow(int i);
        string tag;
        tag = $sformatf("row %0d (instr %h)", i, rowInstr[i]);
        checkFlag(wbValid, expValid[i], {tag, " wbValid"});
        if (expValid[i])
        begin
            checkAddr(wbAddr, expAddr[i], {tag, " wbAddr"});
            checkWord(wbData, expData[i], {tag, " wbData"});
        end
        checkFlag(badInstr, expBad[i], {tag, " badInstr"});
        checkedCount++;
    endtask

    // Row index follows the DUT two edges behind
    always @(posedge clk)
    begin
        stage1 <= (rstN && instrValid) ? curRow : -1;
        stage2 <= stage1;
    end

    always @(negedge clk)
    begin
        if (stage2 >= 0)
            checkRow(stage2);
    end

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Result: FAILED");
            $fatal(1, "Timeout");
        end
    end

    initial
    begin
        instrValid = 1'b0;
        instr      = '0;
        void'($urandom(61279));
        buildTable();
        cycleLimit = rowInstr.size() + RESET_CYCLES + TIMEOUT_MARGIN;
        wait (rstN === 1'b1);
        for (int i = 0; i < rowInstr.size(); i++)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            instrValid = 1'b1;
            instr      = rowInstr[i];
            curRow     = i;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        instrValid = 1'b0;
        wait (checkedCount == rowInstr.size());
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* common/datapathPkg.sv */
package datapathPkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] wordT;

    localparam int REG_COUNT  = 32;
    localparam int REG_ADDR_W = $clog2(REG_COUNT);

    typedef logic [REG_ADDR_W-1:0] regAddrT;

    // HI in the upper word, LO in the lower word
    typedef logic [2*XLEN-1:0] hiLoT;

endpackage

/* common/isaPkg.sv */
package isaPkg;

    localparam int OPCODE_W = 6;
    localparam int FUNC_W   = 6;
    localparam int SHAMT_W  = 5;
    localparam int IMM_W    = 16;

    typedef logic [OPCODE_W-1:0] opcodeT;
    typedef logic [FUNC_W-1:0]   funcT;
    typedef logic [SHAMT_W-1:0]  shamtT;
    typedef logic [IMM_W-1:0]    immT;

    // Primary opcodes
    localparam opcodeT OP_SPECIAL  = 6'h00;
    localparam opcodeT OP_SPECIAL2 = 6'h1C;
    localparam opcodeT OP_ADDI     = 6'h08;
    localparam opcodeT OP_ADDIU    = 6'h09;
    localparam opcodeT OP_SLTI     = 6'h0A;
    localparam opcodeT OP_SLTIU    = 6'h0B;
    localparam opcodeT OP_ANDI     = 6'h0C;
    localparam opcodeT OP_ORI      = 6'h0D;
    localparam opcodeT OP_XORI     = 6'h0E;
    localparam opcodeT OP_LUI      = 6'h0F;

    // SPECIAL function codes
    localparam funcT FN_SLL   = 6'h00;
    localparam funcT FN_SRL   = 6'h02;
    localparam funcT FN_SRA   = 6'h03;
    localparam funcT FN_SLLV  = 6'h04;
    localparam funcT FN_SRLV  = 6'h06;
    localparam funcT FN_SRAV  = 6'h07;
    localparam funcT FN_MOVZ  = 6'h0A;
    localparam funcT FN_MOVN  = 6'h0B;
    localparam funcT FN_MFHI  = 6'h10;
    localparam funcT FN_MTHI  = 6'h11;
    localparam funcT FN_MFLO  = 6'h12;
    localparam funcT FN_MTLO  = 6'h13;
    localparam funcT FN_MULT  = 6'h18;
    localparam funcT FN_MULTU = 6'h19;
    localparam funcT FN_ADD   = 6'h20;
    localparam funcT FN_ADDU  = 6'h21;
    localparam funcT FN_SUB   = 6'h22;
    localparam funcT FN_SUBU  = 6'h23;
    localparam funcT FN_AND   = 6'h24;
    localparam funcT FN_OR    = 6'h25;
    localparam funcT FN_XOR   = 6'h26;
    localparam funcT FN_NOR   = 6'h27;
    localparam funcT FN_SLT   = 6'h2A;
    localparam funcT FN_SLTU  = 6'h2B;

    // SPECIAL2 function codes
    localparam funcT FN_MADD  = 6'h00;
    localparam funcT FN_MADDU = 6'h01;
    localparam funcT FN_MUL   = 6'h02;
    localparam funcT FN_MSUB  = 6'h04;
    localparam funcT FN_MSUBU = 6'h05;

    // Immediate forms share the ALU selection of their register form
    localparam funcT FN_ADDI  = FN_ADD;
    localparam funcT FN_SLTI  = FN_SLT;
    localparam funcT FN_SLTIU = FN_SLTU;
    localparam funcT FN_ANDI  = FN_AND;
    localparam funcT FN_ORI   = FN_OR;
    localparam funcT FN_XORI  = FN_XOR;

endpackage

/* decoder/decoder.sv */
module decoder (
    input  isaPkg::opcodeT opCode,
    input  isaPkg::funcT   funcCode,
    output logic           regDst,
    output logic           aluOp,
    output logic           mulOp,
    output logic           aluSrc,
    output logic           regWrite,
    output logic           shiftSel,
    output logic           immZero,
    output logic           illegal,
    output isaPkg::funcT   func
);
    import isaPkg::*;

    always_comb
    begin
        regDst   = 1'b0;
        aluOp    = 1'b0;
        mulOp    = 1'b0;
        aluSrc   = 1'b0;
        regWrite = 1'b0;
        shiftSel = 1'b0;
        immZero  = 1'b0;
        illegal  = 1'b0;
        func     = '0;

        case (opCode)
            OP_SPECIAL:
                case (funcCode)
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLL, FN_SLLV, FN_SRA,
                    FN_SRAV, FN_SRL, FN_SRLV, FN_AND, FN_NOR, FN_OR, FN_XOR,
                    FN_MOVN, FN_MOVZ, FN_SLT, FN_SLTU:
                        begin
                            regDst   = 1'b1;
                            func     = funcCode;
                            aluOp    = 1'b1;
                            regWrite = 1'b1;
                        end

                    // HI/LO writers, no register result
                    FN_MULT, FN_MULTU, FN_MTHI, FN_MTLO:
                        begin
                            func  = funcCode;
                            aluOp = 1'b1;
                        end

                    // Read back through the HI/LO unit
                    FN_MFHI, FN_MFLO:
                        begin
                            regDst   = 1'b1;
                            func     = funcCode;
                            mulOp    = 1'b1;
                            regWrite = 1'b1;
                        end

                    default:
                        illegal = 1'b1;
                endcase

            OP_SPECIAL2:
                case (funcCode)
                    FN_MADD, FN_MADDU, FN_MSUB, FN_MSUBU:
                        begin
                            func  = funcCode;
                            mulOp = 1'b1;
                        end

                    FN_MUL:
                        begin
                            regDst   = 1'b1;
                            func     = FN_MUL;
                            mulOp    = 1'b1;
                            regWrite = 1'b1;
                        end

                    default:
                        illegal = 1'b1;
                endcase

            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU:
                begin
                    case (opCode)
                        OP_SLTI:  func = FN_SLTI;
                        OP_SLTIU: func = FN_SLTIU;
                        default:  func = FN_ADDI;
                    endcase
                    aluOp    = 1'b1;
                    aluSrc   = 1'b1;
                    regWrite = 1'b1;
                end

            // Logical immediates are zero extended
            OP_ANDI, OP_ORI, OP_XORI:
                begin
                    case (opCode)
                        OP_ANDI: func = FN_ANDI;
                        OP_ORI:  func = FN_ORI;
                        default: func = FN_XORI;
                    endcase
                    aluOp    = 1'b1;
                    aluSrc   = 1'b1;
                    immZero  = 1'b1;
                    regWrite = 1'b1;
                end

            OP_LUI:
                begin
                    func     = FN_ADD;
                    aluOp    = 1'b1;
                    aluSrc   = 1'b1;
                    shiftSel = 1'b1;
                    regWrite = 1'b1;
                end

            default:
                illegal = 1'b1;
        endcase
    end

endmodule

/* hdl/alu.sv */
module alu (
    input  isaPkg::funcT      func,
    input  logic              aluSrc,
    input  logic              shiftSel,
    input  logic              immZero,
    input  datapathPkg::wordT rsData,
    input  datapathPkg::wordT rtData,
    input  isaPkg::shamtT     shamt,
    input  isaPkg::immT       imm,
    output datapathPkg::wordT aluResult,
    output logic              moveOk
);
    import isaPkg::*;
    import datapathPkg::*;

    wordT  immExt;
    wordT  opA;
    wordT  opB;
    shamtT varShift;
    logic  ltSigned;
    logic  ltUnsigned;

    assign immExt = immZero ? {{(XLEN-IMM_W){1'b0}}, imm}
                            : {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};

    // LUI adds the shifted immediate to zero
    assign opA = shiftSel ? '0 : rsData;
    assign opB = !aluSrc ? rtData : (shiftSel ? {imm, {(XLEN-IMM_W){1'b0}}} : immExt);

    assign varShift   = rsData[SHAMT_W-1:0];
    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;

    always_comb
    begin
        moveOk = 1'b1;
        case (func)
            FN_ADD, FN_ADDU: aluResult = opA + opB;
            FN_SUB, FN_SUBU: aluResult = opA - opB;
            FN_SLL:          aluResult = rtData << shamt;
            FN_SLLV:         aluResult = rtData << varShift;
            FN_SRL:          aluResult = rtData >> shamt;
            FN_SRLV:         aluResult = rtData >> varShift;
            FN_SRA:          aluResult = $signed(rtData) >>> shamt;
            FN_SRAV:         aluResult = $signed(rtData) >>> varShift;
            FN_AND:          aluResult = opA & opB;
            FN_OR:           aluResult = opA | opB;
            FN_XOR:          aluResult = opA ^ opB;
            FN_NOR:          aluResult = ~(opA | opB);
            FN_SLT:          aluResult = {{(XLEN-1){1'b0}}, ltSigned};
            FN_SLTU:         aluResult = {{(XLEN-1){1'b0}}, ltUnsigned};
            FN_MOVN:
                begin
                    aluResult = rsData;
                    moveOk    = rtData != '0;
                end
            FN_MOVZ:
                begin
                    aluResult = rsData;
                    moveOk    = rtData == '0;
                end
            default:         aluResult = '0;
        endcase
    end

endmodule

/* hdl/execCore.sv */
module execCore (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 instrValid,
    input  datapathPkg::wordT    instr,
    output logic                 wbValid,
    output datapathPkg::regAddrT wbAddr,
    output datapathPkg::wordT    wbData,
    output logic                 badInstr
);
    import isaPkg::*;
    import datapathPkg::*;

    logic    issueValid;
    opcodeT  opcode;
    funcT    funcCode;
    funcT    func;
    regAddrT rs;
    regAddrT rt;
    regAddrT rd;
    shamtT   shamt;
    immT     imm;
    logic    regDst;
    logic    aluOp;
    logic    mulOp;
    logic    aluSrc;
    logic    regWrite;
    logic    shiftSel;
    logic    immZero;
    logic    illegal;
    logic    moveOk;
    wordT    rsData;
    wordT    rtData;
    wordT    aluResult;
    wordT    mulResult;

    instrLatch uInstrLatch (
        .clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
        .issueValid(issueValid), .opcode(opcode), .funcCode(funcCode),
        .rs(rs), .rt(rt), .rd(rd), .shamt(shamt), .imm(imm)
    );

    decoder uDecoder (
        .opCode(opcode), .funcCode(funcCode), .regDst(regDst), .aluOp(aluOp),
        .mulOp(mulOp), .aluSrc(aluSrc), .regWrite(regWrite), .shiftSel(shiftSel),
        .immZero(immZero), .illegal(illegal), .func(func)
    );

    alu uAlu (
        .func(func), .aluSrc(aluSrc), .shiftSel(shiftSel), .immZero(immZero),
        .rsData(rsData), .rtData(rtData), .shamt(shamt), .imm(imm),
        .aluResult(aluResult), .moveOk(moveOk)
    );

    hiLoUnit uHiLoUnit (
        .clk(clk), .rstN(rstN), .issueValid(issueValid), .mulOp(mulOp),
        .aluOp(aluOp), .func(func), .rsData(rsData), .rtData(rtData),
        .mulResult(mulResult)
    );

    regFile uRegFile (
        .clk(clk), .rstN(rstN), .issueValid(issueValid), .regWrite(regWrite),
        .regDst(regDst), .mulOp(mulOp), .illegal(illegal), .moveOk(moveOk),
        .rs(rs), .rt(rt), .rd(rd), .aluResult(aluResult), .mulResult(mulResult),
        .rsData(rsData), .rtData(rtData), .wbValid(wbValid), .wbAddr(wbAddr),
        .wbData(wbData), .badInstr(badInstr)
    );

endmodule

/* hdl/hiLoUnit.sv */
module hiLoUnit (
    input  logic              clk,
    input  logic              rstN,
    input  logic              issueValid,
    input  logic              mulOp,
    input  logic              aluOp,
    input  isaPkg::funcT      func,
    input  datapathPkg::wordT rsData,
    input  datapathPkg::wordT rtData,
    output datapathPkg::wordT mulResult
);
    import isaPkg::*;
    import datapathPkg::*;

    hiLoT hiLo;
    hiLoT prodS;
    hiLoT prodU;

    // Operands extend to the full product width
    assign prodS = $signed(rsData) * $signed(rtData);
    assign prodU = rsData * rtData;

    always_ff @(posedge clk)
    begin
        if (!rstN)
            hiLo <= '0;
        else if (issueValid && aluOp)
            case (func)
                FN_MULT:  hiLo <= prodS;
                FN_MULTU: hiLo <= prodU;
                FN_MTHI:  hiLo[2*XLEN-1:XLEN] <= rsData;
                FN_MTLO:  hiLo[XLEN-1:0] <= rsData;
                default:  hiLo <= hiLo;
            endcase
        else if (issueValid && mulOp)
            case (func)
                FN_MADD:  hiLo <= hiLo + prodS;
                FN_MADDU: hiLo <= hiLo + prodU;
                FN_MSUB:  hiLo <= hiLo - prodS;
                FN_MSUBU: hiLo <= hiLo - prodU;
                default:  hiLo <= hiLo;
            endcase
    end

    // Low word is the same for signed and unsigned products
    always_comb
    begin
        case (func)
            FN_MFHI: mulResult = hiLo[2*XLEN-1:XLEN];
            FN_MFLO: mulResult = hiLo[XLEN-1:0];
            default: mulResult = prodU[XLEN-1:0];
        endcase
    end

endmodule

/* hdl/instrLatch.sv */
module instrLatch (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 instrValid,
    input  datapathPkg::wordT    instr,
    output logic                 issueValid,
    output isaPkg::opcodeT       opcode,
    output isaPkg::funcT         funcCode,
    output datapathPkg::regAddrT rs,
    output datapathPkg::regAddrT rt,
    output datapathPkg::regAddrT rd,
    output isaPkg::shamtT        shamt,
    output isaPkg::immT          imm
);
    import datapathPkg::*;

    wordT instrQ;

    always_ff @(posedge clk)
    begin
        if (!rstN)
            issueValid <= 1'b0;
        else
            issueValid <= instrValid;
    end

    always_ff @(posedge clk)
    begin
        if (instrValid)
            instrQ <= instr;
    end

    // Field split
    assign opcode   = instrQ[31:26];
    assign rs       = instrQ[25:21];
    assign rt       = instrQ[20:16];
    assign rd       = instrQ[15:11];
    assign shamt    = instrQ[10:6];
    assign funcCode = instrQ[5:0];
    assign imm      = instrQ[15:0];

endmodule

/* hdl/regFile.sv */
module regFile (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 issueValid,
    input  logic                 regWrite,
    input  logic                 regDst,
    input  logic                 mulOp,
    input  logic                 illegal,
    input  logic                 moveOk,
    input  datapathPkg::regAddrT rs,
    input  datapathPkg::regAddrT rt,
    input  datapathPkg::regAddrT rd,
    input  datapathPkg::wordT    aluResult,
    input  datapathPkg::wordT    mulResult,
    output datapathPkg::wordT    rsData,
    output datapathPkg::wordT    rtData,
    output logic                 wbValid,
    output datapathPkg::regAddrT wbAddr,
    output datapathPkg::wordT    wbData,
    output logic                 badInstr
);
    import datapathPkg::*;

    wordT    regs [REG_COUNT];
    regAddrT destAddr;
    wordT    result;
    logic    wrEn;

    assign rsData = (rs == '0) ? '0 : regs[rs];
    assign rtData = (rt == '0) ? '0 : regs[rt];

    assign destAddr = regDst ? rd : rt;
    assign result   = mulOp ? mulResult : aluResult;
    assign wrEn     = issueValid && regWrite && moveOk && (destAddr != '0);

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] <= '0;
            wbValid  <= 1'b0;
            badInstr <= 1'b0;
        end
        else
        begin
            if (wrEn)
                regs[destAddr] <= result;
            wbValid  <= wrEn;
            badInstr <= issueValid && illegal;
        end
    end

    // Writeback report payload
    always_ff @(posedge clk)
    begin
        wbAddr <= destAddr;
        wbData <= result;
    end

endmodule

/* mipsExec.f */
common/isaPkg.sv
common/datapathPkg.sv
hdl/instrLatch.sv
decoder/decoder.sv
hdl/alu.sv
hdl/hiLoUnit.sv
hdl/regFile.sv
hdl/execCore.sv
bench/clockGen.sv
bench/execCoreTb.sv
